/* accel_stimulus.txt */
# columns: kind a b, values in hex
# M addr page | R sel value | E result_addr sum | S sel value (write while busy, sel 3 none)
M 10 0807060504030201
M 11 100f0e0d0c0b0a09
M 12 1817161514131211
M 13 201f1e1d1c1b1a19
R 0 10
R 1 1
R 2 80
E 80 210
S 3 0
M 20 ffffffffffffffff
M 21 ffffffffffffffff
M 22 ffffffffffffffff
M 23 ffffffffffffffff
M 24 0101010101010101
M 25 0202020202020202
M 26 0303030303030303
M 27 0404040404040404
M 28 00000000000000ff
M 29 ff00000000000000
M 2a 8080808080808080
M 2b 0000000000000000
R 0 20
R 1 3
R 2 90
E 90 1fe0
E 91 50
E 92 5fe
S 0 40
R 1 0
S 3 0

/* verilog.f */
+incdir+.
mem_pkg.sv
ctrl_pkg.sv
page_if.sv
page_buffer.sv
ctrl_unit.sv
pixel_unpacker.sv
accel_top.sv
accel_sva.sv
tb_accel.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_accel
FILELIST := verilog.f
BUILD    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

/* tb_accel.sv */
`include "accel_defines.svh"

module tb_accel import mem_pkg::*, ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PAGES          = `ACCEL_PAGES_PER_IMG;

    logic       clk;
    logic       rst_n = 1'b0;
    logic       reg_wr_en = 1'b0;
    reg_sel_t   reg_sel = SEL_IMG_ADDR;
    mem_addr_t  reg_databus = '0;
    logic       begin_proc = 1'b0;
    logic       busy;
    logic       done;
    logic       read_request_valid;
    logic       write_request_valid;
    mem_addr_t  address;
    result_t    write_data;
    logic       data_valid = 1'b0;
    page_t      read_data = '0;
    logic       write_done = 1'b0;
    logic       pix_valid;
    logic [7:0] pix_data;

    page_t       mem [MEM_WORDS];
    logic [31:0] lfsr = 32'h6b019975;
    int          rd_wait = 0;
    int          wr_wait = 0;
    int          lat;
    mem_addr_t   rd_addr;
    int          rd_cnt = 0;
    int          mem_errors = 0;
    int          done_cnt = 0;
    logic [7:0]  pix_q [$];
    mem_addr_t   wr_addr_q [$];
    result_t     wr_data_q [$];
    mem_addr_t   exp_addr_q [$];
    result_t     exp_data_q [$];
    mem_addr_t   m_img_addr = '0;
    mem_addr_t   m_img_cnt = '0;
    mem_addr_t   m_rslt_addr = '0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    accel_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 1 to 4 cycles
    task automatic draw_latency(output int cycles);
        cycles = 1;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            cycles += int'(lfsr[0]) << i;
        end
    endtask

    function automatic page_t page_at(input mem_addr_t a);
        return mem[a[7:0]];
    endfunction

    // memory model, one read in flight at most
    always @(posedge clk) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
            write_done <= 1'b0;
            rd_wait    <= 0;
            wr_wait    <= 0;
        end else begin
            data_valid <= (rd_wait == 1);
            write_done <= (wr_wait == 1);
            if (rd_wait == 1) read_data <= page_at(rd_addr);
            if (rd_wait > 0) rd_wait <= rd_wait - 1;
            if (wr_wait > 0) wr_wait <= wr_wait - 1;
            if (read_request_valid) begin
                if (rd_wait > 0) begin
                    mem_errors <= mem_errors + 1;
                    $display("%0t: read issued while another read is outstanding", $time);
                end
                if (address >= mem_addr_t'(MEM_WORDS)) begin
                    mem_errors <= mem_errors + 1;
                    $display("%0t: read at %0h is outside the memory model", $time, address);
                end
                draw_latency(lat);
                rd_wait <= lat;
                rd_addr <= address;
                rd_cnt  <= rd_cnt + 1;
            end
            if (write_request_valid) begin
                draw_latency(lat);
                wr_wait <= lat;
                wr_addr_q.push_back(address);
                wr_data_q.push_back(write_data);
            end
        end
    end

    always @(negedge clk) begin
        if (pix_valid) pix_q.push_back(pix_data);
        if (done) done_cnt <= done_cnt + 1;
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reg_write(input reg_sel_t sel, input mem_addr_t value);
        @(posedge clk);
        reg_wr_en   <= 1'b1;
        reg_sel     <= sel;
        reg_databus <= value;
        @(posedge clk);
        reg_wr_en <= 1'b0;
    endtask

    task automatic run_test(input int sel, input mem_addr_t value);
        int      cycles;
        int      err0;
        int      rd0;
        int      wr0;
        int      pix0;
        int      done0;
        int      cnt;
        int      idx;
        page_t   pg;
        result_t img_sum;
        err0  = errors;
        rd0   = rd_cnt;
        wr0   = wr_data_q.size();
        pix0  = pix_q.size();
        done0 = done_cnt;
        cnt   = int'(m_img_cnt);
        tests++;
        @(posedge clk);
        begin_proc <= 1'b1;
        @(posedge clk);
        begin_proc <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!busy && cycles < TIMEOUT_CYCLES);
        if (!busy) begin
            errors++;
            $display("test %0d failed: busy never rose after begin_proc", tests);
            return;
        end
        // decoder write while the run is active
        if (sel < 3) reg_write(reg_sel_t'(sel[1:0]), value);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < TIMEOUT_CYCLES);
        if (!done) begin
            errors++;
            $display("test %0d failed: done never pulsed", tests);
            return;
        end
        repeat (3) @(negedge clk);
        compare_value("busy", 64'(0), 64'(busy));
        compare_value("done_pulses", 64'(1), 64'(done_cnt - done0));
        compare_value("read_requests", 64'(PAGES * cnt), 64'(rd_cnt - rd0));
        compare_value("write_requests", 64'(cnt), 64'(wr_data_q.size() - wr0));
        compare_value("pixel_count", 64'(8 * PAGES * cnt), 64'(pix_q.size() - pix0));
        if (exp_data_q.size() != cnt) begin
            errors++;
            $display("test %0d: stimulus gives %0d results for %0d images",
                     tests, exp_data_q.size(), cnt);
        end
        idx = pix0;
        for (int k = 0; k < cnt; k++) begin
            img_sum = '0;
            for (int p = 0; p < PAGES; p++) begin
                pg = page_at(m_img_addr + mem_addr_t'(PAGES * k + p));
                for (int b = 0; b < 8; b++) begin
                    img_sum += result_t'(pg[8*b +: 8]);
                    if (idx < pix_q.size()) begin
                        compare_value("pix_data", 64'(pg[8*b +: 8]), 64'(pix_q[idx]));
                    end
                    idx++;
                end
            end
            if (wr0 + k < wr_data_q.size()) begin
                compare_value("address", 64'(m_rslt_addr + mem_addr_t'(k)),
                              64'(wr_addr_q[wr0 + k]));
                compare_value("write_data", 64'(img_sum), 64'(wr_data_q[wr0 + k]));
                if (k < exp_data_q.size()) begin
                    compare_value("address", 64'(exp_addr_q[k]), 64'(wr_addr_q[wr0 + k]));
                    compare_value("write_data", 64'(exp_data_q[k]), 64'(wr_data_q[wr0 + k]));
                end
            end
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        // image address has walked past the pages just read
        m_img_addr = m_img_addr + mem_addr_t'(PAGES * cnt);
        m_img_cnt  = '0;
        $display("test %0d %s: %0d images, %0d pixels, %0d writes", tests,
                 (errors == err0) ? "ok" : "failed", cnt, pix_q.size() - pix0,
                 wr_data_q.size() - wr0);
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [63:0] a;
        logic [63:0] d;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {32'(i) * 32'h9e3779b1, ~32'(i)};
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        fd = $fopen("accel_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open accel_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 3 || line[0] == "#") continue;
                kind = line[0];
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
                case (kind)
                    "M": mem[a[7:0]] = d;
                    "R": begin
                        reg_write(reg_sel_t'(a[1:0]), mem_addr_t'(d));
                        if (a == 64'd0) m_img_addr = mem_addr_t'(d);
                        if (a == 64'd1) m_img_cnt = mem_addr_t'(d);
                        if (a == 64'd2) m_rslt_addr = mem_addr_t'(d);
                    end
                    "E": begin
                        exp_addr_q.push_back(mem_addr_t'(a));
                        exp_data_q.push_back(result_t'(d));
                    end
                    "S": run_test(int'(a), mem_addr_t'(d));
                    default: begin
                        errors++;
                        $display("unknown line in stimulus file: %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + mem_errors);
        if (errors + mem_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* accel_sva.sv */
`include "accel_defines.svh"

module accel_sva import mem_pkg::*, ctrl_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic read_request_valid,
    input logic data_valid,
    input logic done,
    input logic push,
    input logic full,
    input logic pop
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OCC_W = $clog2(`ACCEL_BUF_DEPTH + 1);

    logic             rd_out;
    logic [OCC_W-1:0] occ;

    // set by a request, cleared by the answer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_out <= 1'b0;
        end else if (read_request_valid) begin
            rd_out <= 1'b1;
        end else if (data_valid) begin
            rd_out <= 1'b0;
        end
    end

    // pages held in the buffer, counted from the strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= '0;
        end else if (push && !pop) begin
            occ <= occ + 1'b1;
        end else if (pop && !push) begin
            occ <= occ - 1'b1;
        end
    end

    one_read: assert property (@(posedge clk) disable iff (!rst_n)
        read_request_valid |-> !rd_out)
        else $error("read request while a read is outstanding");

    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full)
        else $error("page pushed into a full buffer");

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (occ != '0))
        else $error("page popped from an empty buffer");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind accel_top accel_sva u_sva (
    .clk                (clk),
    .rst_n              (rst_n),
    .read_request_valid (read_request_valid),
    .data_valid         (data_valid),
    .done               (done),
    .push               (pif.push),
    .full               (pif.full),
    .pop                (pif.pop)
);

/* accel_top.sv */
`include "accel_defines.svh"

module accel_top
    import mem_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // decoder side
    input  logic       reg_wr_en,
    input  reg_sel_t   reg_sel,
    input  mem_addr_t  reg_databus,
    input  logic       begin_proc,
    output logic       busy,
    output logic       done,

    // memory side
    output logic       read_request_valid,
    output logic       write_request_valid,
    output mem_addr_t  address,
    output result_t    write_data,
    input  logic       data_valid,
    input  page_t      read_data,
    input  logic       write_done,

    // pixel stream
    output logic       pix_valid,
    output logic [7:0] pix_data
);

    logic    sum_valid;
    result_t sum;

    page_if pif ();

    ctrl_unit u_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .reg_wr_en           (reg_wr_en),
        .reg_sel             (reg_sel),
        .reg_databus         (reg_databus),
        .begin_proc          (begin_proc),
        .busy                (busy),
        .done                (done),
        .data_valid          (data_valid),
        .read_data           (read_data),
        .write_done          (write_done),
        .read_request_valid  (read_request_valid),
        .write_request_valid (write_request_valid),
        .address             (address),
        .write_data          (write_data),
        .sum_valid           (sum_valid),
        .sum                 (sum),
        .pif                 (pif.producer)
    );

    page_buffer #(
        .page_type (page_t),
        .DEPTH     (`ACCEL_BUF_DEPTH)
    ) u_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .pif   (pif.fifo)
    );

    pixel_unpacker u_unpack (
        .clk       (clk),
        .rst_n     (rst_n),
        .pif       (pif.consumer),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

endmodule

/* pixel_unpacker.sv */
`include "accel_defines.svh"

module pixel_unpacker import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    page_if.consumer   pif,
    output logic       pix_valid,
    output logic [7:0] pix_data,
    output logic       sum_valid,
    output result_t    sum
);

    localparam int BYTES  = `ACCEL_PAGE_W / 8;
    localparam int BYTE_W = $clog2(BYTES);
    localparam int PG_W   = $clog2(`ACCEL_PAGES_PER_IMG);

    page_t             shreg;
    logic              active;
    logic [BYTE_W-1:0] byte_cnt;
    logic [PG_W-1:0]   page_cnt;
    result_t           acc;
    logic              last_byte;
    logic              last_page;

    assign last_byte = active && (byte_cnt == BYTE_W'(BYTES - 1));
    assign last_page = (page_cnt == PG_W'(`ACCEL_PAGES_PER_IMG - 1));

    // next page may be taken on the last byte of the current one
    assign pif.pop = !pif.empty && (!active || last_byte);

    assign pix_valid = active;
    assign pix_data  = shreg[7:0];

    // low byte goes out first
    always_ff @(posedge clk) begin
        if (pif.pop) begin
            shreg <= pif.rdata;
        end else if (active) begin
            shreg <= shreg >> 8;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            byte_cnt <= '0;
        end else if (pif.pop) begin
            active   <= 1'b1;
            byte_cnt <= '0;
        end else if (active) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (last_byte) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            page_cnt  <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= 1'b0;
            if (active) begin
                if (last_byte && last_page) begin
                    acc       <= '0;
                    sum_valid <= 1'b1;
                end else begin
                    acc <= acc + result_t'(pix_data);
                end
                if (last_byte) begin
                    page_cnt <= last_page ? '0 : page_cnt + 1'b1;
                end
            end
        end
    end

    // final byte of the image folds in here
    always_ff @(posedge clk) begin
        if (last_byte && last_page) begin
            sum <= acc + result_t'(pix_data);
        end
    end

endmodule

/* ctrl_unit.sv */
`include "accel_defines.svh"

module ctrl_unit
    import mem_pkg::*;
    import ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // decoder side
    input  logic            reg_wr_en,
    input  reg_sel_t        reg_sel,
    input  mem_addr_t       reg_databus,
    input  logic            begin_proc,
    output logic            busy,
    output logic            done,

    // memory side
    input  logic            data_valid,
    input  page_t           read_data,
    input  logic            write_done,
    output logic            read_request_valid,
    output logic            write_request_valid,
    output mem_addr_t       address,
    output result_t         write_data,

    // unpacker result
    input  logic            sum_valid,
    input  result_t         sum,

    page_if.producer        pif
);

    localparam int PG_W = $clog2(`ACCEL_PAGES_PER_IMG);

    ctrl_state_t       state;
    mem_addr_t         img_addr;
    mem_addr_t         img_cnt;
    mem_addr_t         rslt_addr;
    mem_addr_t         img_idx;
    logic [PG_W-1:0]   page_cnt;
    result_t           sum_q;
    logic              start;
    logic              page_in;
    logic              last_page;
    logic              img_done;

    assign start     = (state == IDLE) && begin_proc;
    assign page_in   = (state == WAIT_PAGE) && data_valid;
    assign last_page = (page_cnt == PG_W'(`ACCEL_PAGES_PER_IMG - 1));
    assign img_done  = (state == WAIT_WRITE) && write_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (begin_proc) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    // zero count finishes without memory traffic
                    if (img_cnt == '0) begin
                        state <= DONE;
                    end else if (!pif.full) begin
                        state <= WAIT_PAGE;
                    end
                end
                WAIT_PAGE: begin
                    if (data_valid) begin
                        state <= last_page ? WAIT_SUM : FETCH;
                    end
                end
                WAIT_SUM: begin
                    if (sum_valid) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    state <= WAIT_WRITE;
                end
                WAIT_WRITE: begin
                    if (write_done) begin
                        state <= (img_cnt == mem_addr_t'(1)) ? DONE : FETCH;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // decoder registers, locked while a run is active
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_addr  <= '0;
            img_cnt   <= '0;
            rslt_addr <= '0;
        end else if (reg_wr_en && !busy) begin
            case (reg_sel)
                SEL_IMG_ADDR:  img_addr  <= reg_databus;
                SEL_IMG_CNT:   img_cnt   <= reg_databus;
                SEL_RSLT_ADDR: rslt_addr <= reg_databus;
                default:       img_addr  <= img_addr;
            endcase
        end else begin
            if (page_in) begin
                img_addr <= img_addr + 1'b1;
            end
            if (img_done) begin
                img_cnt <= img_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_idx  <= '0;
            page_cnt <= '0;
        end else if (start) begin
            img_idx  <= '0;
            page_cnt <= '0;
        end else begin
            if (page_in) begin
                page_cnt <= last_page ? '0 : page_cnt + 1'b1;
            end
            if (img_done) begin
                img_idx <= img_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == WAIT_SUM) && sum_valid) begin
            sum_q <= sum;
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == DONE);

    assign read_request_valid  = (state == FETCH) && (img_cnt != '0) && !pif.full;
    assign write_request_valid = (state == WRITE);
    // result slot is offset by the image index of this run
    assign address    = write_request_valid ? rslt_addr + img_idx : img_addr;
    assign write_data = sum_q;

    assign pif.push  = page_in;
    assign pif.wdata = read_data;

endmodule

/* page_buffer.sv */
`include "accel_defines.svh"

module page_buffer import mem_pkg::*; #(
    parameter type page_type = page_t,
    parameter int  DEPTH     = `ACCEL_BUF_DEPTH
) (
    input logic  clk,
    input logic  rst_n,
    page_if.fifo pif
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    page_type         mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_en = pif.push && !pif.full;
    assign rd_en = pif.pop && !pif.empty;

    assign pif.full  = (count == CNT_W'(DEPTH));
    assign pif.empty = (count == '0);
    // head entry is visible while not empty
    assign pif.rdata = mem[rptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wptr] <= pif.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wptr <= next_ptr(wptr);
            end
            if (rd_en) begin
                rptr <= next_ptr(rptr);
            end
            // simultaneous push and pop keep the count
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* page_if.sv */
interface page_if import mem_pkg::*; ();

    // write side, from the command unit
    logic  push;
    page_t wdata;
    logic  full;

    // read side, towards the unpacker
    logic  pop;
    page_t rdata;
    logic  empty;

    modport producer (
        output push,
        output wdata,
        input  full
    );

    modport fifo (
        input  push,
        input  wdata,
        input  pop,
        output full,
        output empty,
        output rdata
    );

    modport consumer (
        output pop,
        input  empty,
        input  rdata
    );

endinterface

/* ctrl_pkg.sv */
package ctrl_pkg;

    // command unit FSM
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_PAGE,
        WAIT_SUM,
        WRITE,
        WAIT_WRITE,
        DONE
    } ctrl_state_t;

    // decoder register select
    typedef enum logic [1:0] {
        SEL_IMG_ADDR  = 2'd0,
        SEL_IMG_CNT   = 2'd1,
        SEL_RSLT_ADDR = 2'd2
    } reg_sel_t;

endpackage

/* mem_pkg.sv */
`include "accel_defines.svh"

package mem_pkg;

    // one page as returned by a memory read
    typedef logic [`ACCEL_PAGE_W-1:0] page_t;

    // word address into external memory
    typedef logic [`ACCEL_ADDR_W-1:0] mem_addr_t;

    // byte sum of one image, written back as one word
    typedef logic [31:0] result_t;

endpackage

/* accel_defines.svh */
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// one memory page, in bits
`define ACCEL_PAGE_W 64

// pages making up one image
`define ACCEL_PAGES_PER_IMG 4

// page buffer entries between command unit and unpacker
`define ACCEL_BUF_DEPTH 4

// memory word address width
`define ACCEL_ADDR_W 28

`endif
